//--- hw/rvPkg.sv
`default_nettype none

package rvPkg;

	localparam int xlen = 32;

	// major opcodes, instr[6:0]
	typedef enum logic [6:0] {
		OPC_OP     = 7'b0110011,
		OPC_OP_IMM = 7'b0010011,
		OPC_BRANCH = 7'b1100011,
		OPC_JAL    = 7'b1101111,
		OPC_JALR   = 7'b1100111,
		OPC_LUI    = 7'b0110111,
		OPC_AUIPC  = 7'b0010111,
		OPC_SYSTEM = 7'b1110011
	} opcodeT;

	// {funct7[5], funct3} so register ops map straight across
	typedef enum logic [3:0] {
		ALU_ADD  = 4'b0000,
		ALU_SLL  = 4'b0001,
		ALU_SLT  = 4'b0010,
		ALU_SLTU = 4'b0011,
		ALU_XOR  = 4'b0100,
		ALU_SRL  = 4'b0101,
		ALU_OR   = 4'b0110,
		ALU_AND  = 4'b0111,
		ALU_SUB  = 4'b1000,
		ALU_SRA  = 4'b1101
	} aluOpT;

	// branch funct3
	typedef enum logic [2:0] {
		BR_BEQ  = 3'b000,
		BR_BNE  = 3'b001,
		BR_BLT  = 3'b100,
		BR_BGE  = 3'b101,
		BR_BLTU = 3'b110,
		BR_BGEU = 3'b111
	} branchOpT;

	typedef enum logic [1:0] {
		MOP_MUL    = 2'b00,
		MOP_MULH   = 2'b01,
		MOP_MULHSU = 2'b10,
		MOP_MULHU  = 2'b11
	} mulOpT;

	// low two bits of the csr funct3
	typedef enum logic [1:0] {
		CSR_NONE = 2'b00,
		CSR_RW   = 2'b01,
		CSR_RS   = 2'b10,
		CSR_RC   = 2'b11
	} csrOpT;

	typedef enum logic [2:0] {
		WB_ALU   = 3'd0,
		WB_LINK  = 3'd1,
		WB_MUL   = 3'd2,
		WB_UIMM  = 3'd3,
		WB_AUIPC = 3'd4,
		WB_CSR   = 3'd5
	} wbSelT;

	localparam logic [6:0] f7Base = 7'b0000000;
	localparam logic [6:0] f7Alt = 7'b0100000;   // sub, sra
	localparam logic [6:0] f7MulDiv = 7'b0000001;

	// full encodings of the two privileged words we accept
	localparam logic [31:0] instrEcall = 32'h0000_0073;
	localparam logic [31:0] instrMret = 32'h3020_0073;

endpackage

`default_nettype wire

//--- hw/trapPkg.sv
`default_nettype none

package trapPkg;

	typedef enum logic [1:0] {
		MODE_USER    = 2'd0,
		MODE_SUPER   = 2'd1,
		MODE_MACHINE = 2'd3
	} modeT;

	// mcause code field, the interrupt flag sits above it
	typedef enum logic [30:0] {
		CAUSE_INSTR_MISALIGNED = 31'd0,
		CAUSE_ILLEGAL          = 31'd2,
		CAUSE_S_INT_TIMER      = 31'd5,
		CAUSE_M_INT_TIMER      = 31'd7,
		CAUSE_U_CALL           = 31'd8,   // + mode for S and M calls
		CAUSE_S_INT_EXT        = 31'd9,
		CAUSE_M_INT_EXT        = 31'd11
	} causeT;

	localparam int intrBit = 31;

endpackage

`default_nettype wire

//--- hw/pipeIfs.sv
`timescale 1ns/1ps
`default_nettype none

// decoded instruction handed from decode into stage 5
interface exeCtrlIf import rvPkg::*, trapPkg::*; ();
	logic valid;
	logic [xlen-1:0] pc;
	logic [xlen-1:0] rs1Val;
	logic [xlen-1:0] rs2Val;
	logic [xlen-1:0] imm;
	aluOpT aluOp;
	branchOpT branchOp;
	mulOpT mulOp;
	csrOpT csrOp;
	logic isBranch;
	logic isJal;
	logic isJalr;
	logic useImm;
	logic csrUseImm;
	logic csrWriteKill;   // rs/rc with a zero source
	logic [11:0] csrAddr;
	logic [xlen-1:0] csrRdata;
	logic [4:0] rd;
	logic we;
	wbSelT wbSel;
	logic isEcall;
	logic isMret;
	logic illegal;
	modeT mode;

	modport dec (output valid, pc, rs1Val, rs2Val, imm, aluOp, branchOp, mulOp, csrOp,
		isBranch, isJal, isJalr, useImm, csrUseImm, csrWriteKill, csrAddr, csrRdata,
		rd, we, wbSel, isEcall, isMret, illegal, mode);
	modport exe (input valid, pc, rs1Val, rs2Val, imm, aluOp, branchOp, mulOp, csrOp,
		isBranch, isJal, isJalr, useImm, csrUseImm, csrWriteKill, csrAddr, csrRdata,
		rd, we, wbSel, isEcall, isMret, illegal, mode);
endinterface

// execute results on their way into stage 6
interface exeResultIf import rvPkg::*, trapPkg::*; ();
	logic valid;
	logic [xlen-1:0] pc;
	logic [4:0] rd;
	logic we;
	wbSelT wbSel;
	logic [xlen-1:0] aluRes;
	logic [xlen-1:0] mulRes;
	logic [xlen-1:0] uImm;
	logic [xlen-1:0] auipcRes;
	logic [xlen-1:0] csrOld;
	logic [xlen-1:0] csrNew;
	logic [11:0] csrAddr;
	logic csrWe;
	logic redirect;
	logic [xlen-1:0] target;
	logic targetMisaligned;
	logic isEcall;
	logic isMret;
	logic illegal;
	modeT mode;

	modport exe (output valid, pc, rd, we, wbSel, aluRes, mulRes, uImm, auipcRes,
		csrOld, csrNew, csrAddr, csrWe, redirect, target, targetMisaligned,
		isEcall, isMret, illegal, mode);
	modport res (input valid, pc, rd, we, wbSel, aluRes, mulRes, uImm, auipcRes,
		csrOld, csrNew, csrAddr, csrWe, redirect, target, targetMisaligned,
		isEcall, isMret, illegal, mode);
endinterface

`default_nettype wire

//--- hw/aluUnit.sv
`timescale 1ns/1ps
`default_nettype none

module aluUnit import rvPkg::*; (
	input aluOpT aluOp,
	input branchOpT branchOp,
	input logic [xlen-1:0] operandA,
	input logic [xlen-1:0] operandB,
	output logic [xlen-1:0] result,
	output logic branchTaken
);

	logic [4:0] shamt;
	logic isEq;
	logic isLt;
	logic isLtu;

	assign shamt = operandB[4:0];
	assign isEq = operandA == operandB;
	assign isLt = $signed(operandA) < $signed(operandB);
	assign isLtu = operandA < operandB;

	always_comb
	begin
		case (aluOp)
			ALU_ADD:  result = operandA + operandB;
			ALU_SUB:  result = operandA - operandB;
			ALU_SLL:  result = operandA << shamt;
			ALU_SLT:  result = {{(xlen-1){1'b0}}, isLt};
			ALU_SLTU: result = {{(xlen-1){1'b0}}, isLtu};
			ALU_XOR:  result = operandA ^ operandB;
			ALU_SRL:  result = operandA >> shamt;
			ALU_SRA:  result = $signed(operandA) >>> shamt;
			ALU_OR:   result = operandA | operandB;
			ALU_AND:  result = operandA & operandB;
			default:  result = '0;
		endcase
	end

	// compare on the raw register operands, same cycle as the ALU
	always_comb
	begin
		case (branchOp)
			BR_BEQ:  branchTaken = isEq;
			BR_BNE:  branchTaken = !isEq;
			BR_BLT:  branchTaken = isLt;
			BR_BGE:  branchTaken = !isLt;
			BR_BLTU: branchTaken = isLtu;
			BR_BGEU: branchTaken = !isLtu;
			default: branchTaken = 1'b0;
		endcase
	end

	// decoder must never hand over an undefined or unknown op
	always_comb
	begin
		if (!$isunknown({operandA, operandB}))
			assert (aluOp inside {ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
				ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND})
			else $error("aluUnit: bad aluOp %b", aluOp);
	end

endmodule

`default_nettype wire

//--- hw/mulUnit.sv
`timescale 1ns/1ps
`default_nettype none

module mulUnit import rvPkg::*; (
	input mulOpT mulOp,
	input logic [xlen-1:0] a,
	input logic [xlen-1:0] b,
	output logic [xlen-1:0] res
);

	logic aSigned;
	logic bSigned;
	logic signed [xlen:0] aExt;
	logic signed [xlen:0] bExt;
	logic signed [2*xlen+1:0] product;

	// low word does not care about signedness
	assign aSigned = mulOp != MOP_MULHU;
	assign bSigned = mulOp == MOP_MULH || mulOp == MOP_MUL;

	assign aExt = {aSigned & a[xlen-1], a};
	assign bExt = {bSigned & b[xlen-1], b};
	assign product = aExt * bExt;

	assign res = (mulOp == MOP_MUL) ? product[xlen-1:0] : product[2*xlen-1:xlen];

endmodule

`default_nettype wire

//--- hw/instrDecode.sv
`timescale 1ns/1ps
`default_nettype none

module instrDecode import rvPkg::*, trapPkg::*; (
	input logic [31:0] instr,
	input logic instrValid,
	input logic [xlen-1:0] pc,
	input logic [xlen-1:0] rs1Val,
	input logic [xlen-1:0] rs2Val,
	input logic [xlen-1:0] csrRdata,
	input modeT mode,
	exeCtrlIf.dec ctrl
);

	opcodeT opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic [4:0] rs1Field;
	logic isShift;
	logic [xlen-1:0] immI;
	logic [xlen-1:0] immB;
	logic [xlen-1:0] immJ;
	logic [xlen-1:0] immU;

	assign opcode = opcodeT'(instr[6:0]);
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];
	assign rs1Field = instr[19:15];
	assign isShift = funct3[1:0] == 2'b01;

	assign immI = {{20{instr[31]}}, instr[31:20]};
	assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
	assign immU = {instr[31:12], 12'b0};

	// operands ride along untouched
	assign ctrl.valid = instrValid;
	assign ctrl.pc = pc;
	assign ctrl.rs1Val = rs1Val;
	assign ctrl.rs2Val = rs2Val;
	assign ctrl.csrRdata = csrRdata;
	assign ctrl.mode = mode;
	assign ctrl.rd = instr[11:7];
	assign ctrl.csrAddr = instr[31:20];

	always_comb
	begin
		ctrl.imm = immI;
		ctrl.aluOp = ALU_ADD;
		ctrl.branchOp = BR_BEQ;
		ctrl.mulOp = mulOpT'(funct3[1:0]);
		ctrl.csrOp = CSR_NONE;
		ctrl.isBranch = 1'b0;
		ctrl.isJal = 1'b0;
		ctrl.isJalr = 1'b0;
		ctrl.useImm = 1'b0;
		ctrl.csrUseImm = 1'b0;
		ctrl.csrWriteKill = 1'b0;
		ctrl.we = 1'b0;
		ctrl.wbSel = WB_ALU;
		ctrl.isEcall = 1'b0;
		ctrl.isMret = 1'b0;
		ctrl.illegal = 1'b0;

		case (opcode)
			OPC_OP:
			begin
				ctrl.we = 1'b1;
				if (funct7 == f7MulDiv)
				begin
					ctrl.wbSel = WB_MUL;
					ctrl.illegal = funct3[2];   // div and rem not built
				end
				else if (funct7 == f7Base
					|| (funct7 == f7Alt && (funct3 == 3'b000 || funct3 == 3'b101)))
					ctrl.aluOp = aluOpT'({funct7[5], funct3});
				else
					ctrl.illegal = 1'b1;
			end
			OPC_OP_IMM:
			begin
				ctrl.we = 1'b1;
				ctrl.useImm = 1'b1;
				// only shifts look at funct7
				if (isShift && funct7 != f7Base && !(funct3[2] && funct7 == f7Alt))
					ctrl.illegal = 1'b1;
				ctrl.aluOp = aluOpT'({isShift & funct3[2] & funct7[5], funct3});
			end
			OPC_BRANCH:
			begin
				ctrl.isBranch = 1'b1;
				ctrl.imm = immB;
				if (funct3[2:1] == 2'b01)
					ctrl.illegal = 1'b1;
				else
					ctrl.branchOp = branchOpT'(funct3);
			end
			OPC_JAL:
			begin
				ctrl.isJal = 1'b1;
				ctrl.imm = immJ;
				ctrl.we = 1'b1;
				ctrl.wbSel = WB_LINK;
			end
			OPC_JALR:
			begin
				ctrl.isJalr = 1'b1;
				ctrl.we = 1'b1;
				ctrl.wbSel = WB_LINK;
				ctrl.illegal = funct3 != 3'b000;
			end
			OPC_LUI:
			begin
				ctrl.imm = immU;
				ctrl.we = 1'b1;
				ctrl.wbSel = WB_UIMM;
			end
			OPC_AUIPC:
			begin
				ctrl.imm = immU;
				ctrl.we = 1'b1;
				ctrl.wbSel = WB_AUIPC;
			end
			OPC_SYSTEM:
			begin
				if (funct3 == 3'b000)
				begin
					if (instr == instrEcall)
						ctrl.isEcall = 1'b1;
					else if (instr == instrMret && mode == MODE_MACHINE)
						ctrl.isMret = 1'b1;
					else
						ctrl.illegal = 1'b1;   // includes mret below machine
				end
				else if (funct3[1:0] == 2'b00)
					ctrl.illegal = 1'b1;
				else
				begin
					ctrl.csrOp = csrOpT'(funct3[1:0]);
					ctrl.csrUseImm = funct3[2];
					ctrl.imm = {27'b0, rs1Field};   // zimm
					ctrl.csrWriteKill = funct3[1] && rs1Field == 5'd0;
					ctrl.we = 1'b1;
					ctrl.wbSel = WB_CSR;
				end
			end
			default: ctrl.illegal = 1'b1;
		endcase
	end

endmodule

`default_nettype wire

//--- hw/exeStage.sv
`timescale 1ns/1ps
`default_nettype none

module exeStage import rvPkg::*, trapPkg::*; (
	input logic clk,
	input logic nrst,
	input logic flush,
	exeCtrlIf.exe ctrl,
	exeResultIf.exe res
);

	logic valid5;
	logic [xlen-1:0] pc5;
	logic [xlen-1:0] rs1Val5;
	logic [xlen-1:0] rs2Val5;
	logic [xlen-1:0] imm5;
	logic [xlen-1:0] csrRdata5;
	aluOpT aluOp5;
	branchOpT branchOp5;
	mulOpT mulOp5;
	csrOpT csrOp5;
	logic isBranch5;
	logic isJal5;
	logic isJalr5;
	logic useImm5;
	logic csrUseImm5;
	logic csrWriteKill5;
	logic [11:0] csrAddr5;
	logic [4:0] rd5;
	logic we5;
	wbSelT wbSel5;
	logic isEcall5;
	logic isMret5;
	logic illegal5;
	modeT mode5;

	logic [xlen-1:0] operandB;
	logic [xlen-1:0] csrSrc;
	logic branchTaken;

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
			valid5 <= 1'b0;
		else
			valid5 <= ctrl.valid;   // entering instruction survives a flush edge
	end

	always_ff @(posedge clk)
	begin
		if (ctrl.valid)
		begin
			pc5 <= ctrl.pc;
			rs1Val5 <= ctrl.rs1Val;
			rs2Val5 <= ctrl.rs2Val;
			imm5 <= ctrl.imm;
			csrRdata5 <= ctrl.csrRdata;
			aluOp5 <= ctrl.aluOp;
			branchOp5 <= ctrl.branchOp;
			mulOp5 <= ctrl.mulOp;
			csrOp5 <= ctrl.csrOp;
			isBranch5 <= ctrl.isBranch;
			isJal5 <= ctrl.isJal;
			isJalr5 <= ctrl.isJalr;
			useImm5 <= ctrl.useImm;
			csrUseImm5 <= ctrl.csrUseImm;
			csrWriteKill5 <= ctrl.csrWriteKill;
			csrAddr5 <= ctrl.csrAddr;
			rd5 <= ctrl.rd;
			we5 <= ctrl.we;
			wbSel5 <= ctrl.wbSel;
			isEcall5 <= ctrl.isEcall;
			isMret5 <= ctrl.isMret;
			illegal5 <= ctrl.illegal;
			mode5 <= ctrl.mode;
		end
	end

	assign operandB = useImm5 ? imm5 : rs2Val5;

	aluUnit alu (
		.aluOp(aluOp5),
		.branchOp(branchOp5),
		.operandA(rs1Val5),
		.operandB(operandB),
		.result(res.aluRes),
		.branchTaken(branchTaken)
	);

	mulUnit mul (
		.mulOp(mulOp5),
		.a(rs1Val5),
		.b(rs2Val5),
		.res(res.mulRes)
	);

	// trap in stage 6 kills what is leaving stage 5
	assign res.valid = valid5 && !flush;

	assign res.target = isJalr5 ? ((rs1Val5 + imm5) & ~{{(xlen-1){1'b0}}, 1'b1})
		: pc5 + imm5;
	assign res.redirect = (isBranch5 && branchTaken) || isJal5 || isJalr5;
	assign res.targetMisaligned = res.redirect && res.target[1];

	assign csrSrc = csrUseImm5 ? imm5 : rs1Val5;

	always_comb
	begin
		case (csrOp5)
			CSR_RW:  res.csrNew = csrSrc;
			CSR_RS:  res.csrNew = csrRdata5 | csrSrc;
			CSR_RC:  res.csrNew = csrRdata5 & ~csrSrc;
			default: res.csrNew = csrRdata5;
		endcase
	end

	assign res.csrWe = csrOp5 != CSR_NONE && !csrWriteKill5;
	assign res.csrOld = csrRdata5;
	assign res.csrAddr = csrAddr5;

	assign res.pc = pc5;
	assign res.rd = rd5;
	assign res.we = we5;
	assign res.wbSel = wbSel5;
	assign res.uImm = imm5;
	assign res.auipcRes = pc5 + imm5;
	assign res.isEcall = isEcall5;
	assign res.isMret = isMret5;
	assign res.illegal = illegal5;
	assign res.mode = mode5;

	// decoder sets at most one control-flow flag per instruction
	redirectOneHot: assert property (@(posedge clk) disable iff (!nrst)
		res.valid && res.redirect |-> $onehot({isBranch5, isJal5, isJalr5}));

endmodule

`default_nettype wire

//--- hw/resultStage.sv
`timescale 1ns/1ps
`default_nettype none

module resultStage import rvPkg::*, trapPkg::*; (
	input logic clk,
	input logic nrst,
	input modeT mode,
	input logic mTimer,
	input logic sTimer,
	input logic extIrq,
	input logic mTie,
	input logic sTie,
	input logic mEie,
	input logic sEie,
	exeResultIf.res res,
	output logic flush,
	output logic wbWe,
	output logic [4:0] wbRd,
	output logic [xlen-1:0] wbData,
	output logic csrWe,
	output logic [11:0] csrAddr,
	output logic [xlen-1:0] csrWdata,
	output logic redirectValid,
	output logic [xlen-1:0] redirectTarget,
	output logic trapValid,
	output logic [xlen-1:0] trapCause,
	output logic mret
);

	logic valid6;
	logic [xlen-1:0] pc6;
	logic [4:0] rd6;
	logic we6;
	wbSelT wbSel6;
	logic [xlen-1:0] aluRes6;
	logic [xlen-1:0] mulRes6;
	logic [xlen-1:0] uImm6;
	logic [xlen-1:0] auipcRes6;
	logic [xlen-1:0] csrOld6;
	logic [xlen-1:0] csrNew6;
	logic [11:0] csrAddr6;
	logic csrWe6;
	logic redirect6;
	logic [xlen-1:0] target6;
	logic misaligned6;
	logic isEcall6;
	logic isMret6;
	logic illegal6;
	modeT mode6;

	logic belowMachine;
	logic mExt;
	logic sExt;
	logic mTim;
	logic sTim;
	logic isIntr;
	logic [intrBit-1:0] causeCode;

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
			valid6 <= 1'b0;
		else
			valid6 <= res.valid;
	end

	always_ff @(posedge clk)
	begin
		if (res.valid)
		begin
			pc6 <= res.pc;
			rd6 <= res.rd;
			we6 <= res.we;
			wbSel6 <= res.wbSel;
			aluRes6 <= res.aluRes;
			mulRes6 <= res.mulRes;
			uImm6 <= res.uImm;
			auipcRes6 <= res.auipcRes;
			csrOld6 <= res.csrOld;
			csrNew6 <= res.csrNew;
			csrAddr6 <= res.csrAddr;
			csrWe6 <= res.csrWe;
			redirect6 <= res.redirect;
			target6 <= res.target;
			misaligned6 <= res.targetMisaligned;
			isEcall6 <= res.isEcall;
			isMret6 <= res.isMret;
			illegal6 <= res.illegal;
			mode6 <= res.mode;
		end
	end

	// interrupts only attach to a live instruction
	assign belowMachine = mode != MODE_MACHINE;
	assign mExt = valid6 && mEie && extIrq;
	assign sExt = valid6 && sEie && extIrq && belowMachine;
	assign mTim = valid6 && mTie && mTimer;
	assign sTim = valid6 && sTie && sTimer && belowMachine;

	always_comb
	begin
		trapValid = 1'b1;
		isIntr = 1'b1;
		mret = 1'b0;
		causeCode = CAUSE_INSTR_MISALIGNED;
		if (mExt)
			causeCode = CAUSE_M_INT_EXT;
		else if (sExt)
			causeCode = CAUSE_S_INT_EXT;
		else if (mTim)
			causeCode = CAUSE_M_INT_TIMER;
		else if (sTim)
			causeCode = CAUSE_S_INT_TIMER;
		else
		begin
			isIntr = 1'b0;
			if (valid6 && illegal6)
				causeCode = CAUSE_ILLEGAL;
			else if (valid6 && isEcall6)
				causeCode = CAUSE_U_CALL + intrBit'(mode6);
			else if (valid6 && misaligned6)
				causeCode = CAUSE_INSTR_MISALIGNED;
			else if (valid6 && isMret6)
				mret = 1'b1;   // cause stays 0
			else
				trapValid = 1'b0;
		end
	end

	assign trapCause = {isIntr, causeCode};
	assign flush = trapValid;

	always_comb
	begin
		case (wbSel6)
			WB_LINK:  wbData = pc6 + 32'd4;
			WB_MUL:   wbData = mulRes6;
			WB_UIMM:  wbData = uImm6;
			WB_AUIPC: wbData = auipcRes6;
			WB_CSR:   wbData = csrOld6;
			default:  wbData = aluRes6;
		endcase
	end

	assign wbWe = valid6 && we6 && rd6 != 5'd0 && !trapValid;   // x0 never written
	assign wbRd = rd6;
	assign csrWe = valid6 && csrWe6 && !trapValid;
	assign csrAddr = csrAddr6;
	assign csrWdata = csrNew6;
	assign redirectValid = valid6 && redirect6 && !trapValid;
	assign redirectTarget = target6;

	// the follower squashed by a trap never reaches stage 6
	squashAfterTrap: assert property (@(posedge clk) disable iff (!nrst)
		trapValid |=> !valid6);

endmodule

`default_nettype wire

//--- hw/execCore.sv
`timescale 1ns/1ps
`default_nettype none

module execCore import rvPkg::*, trapPkg::*; (
	input logic clk,
	input logic nrst,
	input logic [31:0] instr,
	input logic instrValid,
	input logic [xlen-1:0] pc,
	input logic [xlen-1:0] rs1Val,
	input logic [xlen-1:0] rs2Val,
	input logic [xlen-1:0] csrRdata,
	input modeT mode,
	input logic mTimer,
	input logic sTimer,
	input logic extIrq,
	input logic mTie,
	input logic sTie,
	input logic mEie,
	input logic sEie,
	output logic wbWe,
	output logic [4:0] wbRd,
	output logic [xlen-1:0] wbData,
	output logic csrWe,
	output logic [11:0] csrAddr,
	output logic [xlen-1:0] csrWdata,
	output logic redirectValid,
	output logic [xlen-1:0] redirectTarget,
	output logic trapValid,
	output logic [xlen-1:0] trapCause,
	output logic mret
);

	logic flush;

	exeCtrlIf ctrlBus ();
	exeResultIf resBus ();

	instrDecode decode (
		.instr(instr),
		.instrValid(instrValid),
		.pc(pc),
		.rs1Val(rs1Val),
		.rs2Val(rs2Val),
		.csrRdata(csrRdata),
		.mode(mode),
		.ctrl(ctrlBus.dec)
	);

	exeStage execute (
		.clk(clk),
		.nrst(nrst),
		.flush(flush),
		.ctrl(ctrlBus.exe),
		.res(resBus.exe)
	);

	// trap, writeback and redirect all leave from stage 6
	resultStage result (
		.clk(clk),
		.nrst(nrst),
		.mode(mode),
		.mTimer(mTimer),
		.sTimer(sTimer),
		.extIrq(extIrq),
		.mTie(mTie),
		.sTie(sTie),
		.mEie(mEie),
		.sEie(sEie),
		.res(resBus.res),
		.flush(flush),
		.wbWe(wbWe),
		.wbRd(wbRd),
		.wbData(wbData),
		.csrWe(csrWe),
		.csrAddr(csrAddr),
		.csrWdata(csrWdata),
		.redirectValid(redirectValid),
		.redirectTarget(redirectTarget),
		.trapValid(trapValid),
		.trapCause(trapCause),
		.mret(mret)
	);

endmodule

`default_nettype wire

//--- verification/execCoreTb.sv
`timescale 1ns/1ps
`default_nettype none

module execCoreTb import rvPkg::*, trapPkg::*; ();

	localparam string caseFile = "verification/execCases.txt";
	localparam int halfPeriod = 4;   // 8 ns clock
	localparam int resetCycles = 8;
	localparam int maxCases = 64;
	localparam int latency = 2;   // input edge to output

	logic clk;
	logic nrst;
	logic [31:0] instr;
	logic instrValid;
	logic [xlen-1:0] pc;
	logic [xlen-1:0] rs1Val;
	logic [xlen-1:0] rs2Val;
	logic [xlen-1:0] csrRdata;
	modeT mode;
	logic mTimer;
	logic sTimer;
	logic extIrq;
	logic mTie;
	logic sTie;
	logic mEie;
	logic sEie;
	logic wbWe;
	logic [4:0] wbRd;
	logic [xlen-1:0] wbData;
	logic csrWe;
	logic [11:0] csrAddr;
	logic [xlen-1:0] csrWdata;
	logic redirectValid;
	logic [xlen-1:0] redirectTarget;
	logic trapValid;
	logic [xlen-1:0] trapCause;
	logic mret;

	// case table, one entry per line of the case file
	string caseName [maxCases];
	int gapCnt [maxCases];
	logic [31:0] inInstr [maxCases];
	logic [31:0] inPc [maxCases];
	logic [31:0] inRs1 [maxCases];
	logic [31:0] inRs2 [maxCases];
	logic [31:0] inCsr [maxCases];
	logic [1:0] inMode [maxCases];
	logic [6:0] inIrq [maxCases];   // mTimer sTimer extIrq mTie sTie mEie sEie
	logic squashed [maxCases];
	logic expWbWe [maxCases];
	logic [4:0] expWbRd [maxCases];
	logic [31:0] expWbData [maxCases];
	logic expCsrWe [maxCases];
	logic [11:0] expCsrAddr [maxCases];
	logic [31:0] expCsrWdata [maxCases];
	logic expRedirect [maxCases];
	logic [31:0] expTarget [maxCases];
	logic expTrap [maxCases];
	logic [31:0] expCause [maxCases];
	logic expMret [maxCases];

	int numCases = 0;
	int limitCycles = 0;
	int cycle = 0;
	int dueIdx;
	int idxQ [$];
	int dueQ [$];

	execCore dut (
		.clk(clk), .nrst(nrst), .instr(instr), .instrValid(instrValid), .pc(pc),
		.rs1Val(rs1Val), .rs2Val(rs2Val), .csrRdata(csrRdata), .mode(mode),
		.mTimer(mTimer), .sTimer(sTimer), .extIrq(extIrq), .mTie(mTie), .sTie(sTie),
		.mEie(mEie), .sEie(sEie), .wbWe(wbWe), .wbRd(wbRd), .wbData(wbData),
		.csrWe(csrWe), .csrAddr(csrAddr), .csrWdata(csrWdata),
		.redirectValid(redirectValid), .redirectTarget(redirectTarget),
		.trapValid(trapValid), .trapCause(trapCause), .mret(mret)
	);

	always #halfPeriod clk = ~clk;

	always @(posedge clk)
		cycle <= cycle + 1;

	task automatic abortRun(input string msg);
		$display("ERROR: %s", msg);
		$display("Result: FAILED");
		$fatal(1, "run aborted");
	endtask

	task automatic checkValue(input string name, input string field,
		input logic [31:0] expVal, input logic [31:0] actVal);
		if (actVal !== expVal)
		begin
			$display("FAILED %s %s expected %h actual %h", name, field, expVal, actVal);
			$display("Result: FAILED");
			$fatal(1, "output mismatch");
		end
	endtask

	task automatic checkOutputs(input int i);
		checkValue(caseName[i], "wbWe", 32'(expWbWe[i]), 32'(wbWe));
		checkValue(caseName[i], "csrWe", 32'(expCsrWe[i]), 32'(csrWe));
		checkValue(caseName[i], "redirectValid", 32'(expRedirect[i]), 32'(redirectValid));
		checkValue(caseName[i], "trapValid", 32'(expTrap[i]), 32'(trapValid));
		checkValue(caseName[i], "mret", 32'(expMret[i]), 32'(mret));
		// payloads only mean something while their valid is up
		if (expWbWe[i])
		begin
			checkValue(caseName[i], "wbRd", 32'(expWbRd[i]), 32'(wbRd));
			checkValue(caseName[i], "wbData", expWbData[i], wbData);
		end
		if (expCsrWe[i])
		begin
			checkValue(caseName[i], "csrAddr", 32'(expCsrAddr[i]), 32'(csrAddr));
			checkValue(caseName[i], "csrWdata", expCsrWdata[i], csrWdata);
		end
		if (expRedirect[i])
			checkValue(caseName[i], "redirectTarget", expTarget[i], redirectTarget);
		if (expTrap[i])
			checkValue(caseName[i], "trapCause", expCause[i], trapCause);
	endtask

	task automatic readCases();
		int fd;
		int n;
		string line;
		fd = $fopen(caseFile, "r");
		if (fd == 0)
			abortRun({"cannot open case file ", caseFile});
		while (!$feof(fd))
		begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() < 2 || line.getc(0) == "#")
				continue;
			if (numCases == maxCases)
				abortRun("too many cases in the case file");
			n = $sscanf(line, "%s %d %h %h %h %h %h %d %b %d %d %d %h %d %h %h %d %h %d %h %d",
				caseName[numCases], gapCnt[numCases], inInstr[numCases], inPc[numCases],
				inRs1[numCases], inRs2[numCases], inCsr[numCases], inMode[numCases],
				inIrq[numCases], squashed[numCases], expWbWe[numCases], expWbRd[numCases],
				expWbData[numCases], expCsrWe[numCases], expCsrAddr[numCases],
				expCsrWdata[numCases], expRedirect[numCases], expTarget[numCases],
				expTrap[numCases], expCause[numCases], expMret[numCases]);
			if (n != 21)
				abortRun({"malformed line in case file: ", line});
			limitCycles += gapCnt[numCases] + 4;
			numCases++;
		end
		$fclose(fd);
		limitCycles += 20;
	endtask

	task automatic issueCase(input int i);
		repeat (gapCnt[i])
		begin
			@(posedge clk);
			#1;
			instrValid = 1'b0;
		end
		@(posedge clk);
		#1;
		instr = inInstr[i];
		pc = inPc[i];
		rs1Val = inRs1[i];
		rs2Val = inRs2[i];
		csrRdata = inCsr[i];
		mode = modeT'(inMode[i]);
		{mTimer, sTimer, extIrq, mTie, sTie, mEie, sEie} = inIrq[i];
		instrValid = 1'b1;
		if (!squashed[i])
		begin
			idxQ.push_back(i);
			dueQ.push_back(cycle + latency);
		end
	endtask

	// compare on the falling edge, outputs settled from stage 6
	always @(negedge clk)
	begin
		if (nrst)
		begin
			if (dueQ.size() > 0 && dueQ[0] == cycle)
			begin
				dueIdx = idxQ.pop_front();
				void'(dueQ.pop_front());
				checkOutputs(dueIdx);
			end
			else if (wbWe || csrWe || redirectValid || trapValid || mret)
				abortRun($sformatf("output active in cycle %0d with no instruction due", cycle));
		end
	end

	initial
	begin
		wait (limitCycles > 0);
		repeat (limitCycles) @(posedge clk);
		$display("ERROR: timeout, run did not finish within %0d cycles", limitCycles);
		$display("Result: FAILED");
		$fatal(1, "watchdog expired");
	end

	initial
	begin
		clk = 1'b0;
		nrst = 1'b0;
		instr = '0;
		instrValid = 1'b0;
		pc = '0;
		rs1Val = '0;
		rs2Val = '0;
		csrRdata = '0;
		mode = MODE_MACHINE;
		{mTimer, sTimer, extIrq, mTie, sTie, mEie, sEie} = '0;
		readCases();
		repeat (resetCycles) @(posedge clk);
		#1;
		nrst = 1'b1;
		for (int i = 0; i < numCases; i++)
			issueCase(i);
		@(posedge clk);
		#1;
		instrValid = 1'b0;
		while (dueQ.size() > 0)
			@(posedge clk);
		repeat (4) @(posedge clk);   // nothing stray after the last result
		$display("Result: PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- verification/execCases.txt
# name gap instr pc rs1 rs2 csrRdata mode irq(mTim sTim ext mTie sTie mEie sEie) squashed
#   then expected: wbWe wbRd wbData csrWe csrAddr csrWdata redirect target trap cause mret
add_ovf 0 002081b3 100 7fffffff 1 0 3 0000000 0 1 3 80000000 0 0 0 0 0 0 0 0
sub 0 402081b3 104 3 5 0 3 0000000 0 1 3 fffffffe 0 0 0 0 0 0 0 0
sra 0 4020d1b3 108 80000010 4 0 3 0000000 0 1 3 f8000001 0 0 0 0 0 0 0 0
sltu 0 0020b1b3 10c 1 ffffffff 0 3 0000000 0 1 3 1 0 0 0 0 0 0 0 0
slt 0 0020a1b3 110 ffffffff 1 0 3 0000000 0 1 3 1 0 0 0 0 0 0 0 0
addi_neg 0 fff08193 114 10 0 0 3 0000000 0 1 3 f 0 0 0 0 0 0 0 0
xori 0 0f00c193 118 ff 0 0 3 0000000 0 1 3 f 0 0 0 0 0 0 0 0
slli 0 00809193 11c 12345678 0 0 3 0000000 0 1 3 34567800 0 0 0 0 0 0 0 0
addi_x0 0 00508013 120 1 0 0 3 0000000 0 0 0 0 0 0 0 0 0 0 0 0
lui 0 123451b7 124 0 0 0 3 0000000 0 1 3 12345000 0 0 0 0 0 0 0 0
auipc 0 00001197 100 0 0 0 3 0000000 0 1 3 1100 0 0 0 0 0 0 0 0
mul 0 022081b3 128 ffffffff ffffffff 0 3 0000000 0 1 3 1 0 0 0 0 0 0 0 0
mulh 0 022091b3 12c ffffffff ffffffff 0 3 0000000 0 1 3 0 0 0 0 0 0 0 0 0
mulhsu 0 0220a1b3 130 ffffffff ffffffff 0 3 0000000 0 1 3 ffffffff 0 0 0 0 0 0 0 0
mulhu 0 0220b1b3 134 ffffffff ffffffff 0 3 0000000 0 1 3 fffffffe 0 0 0 0 0 0 0 0
beq_t 0 00208863 200 5 5 0 3 0000000 0 0 0 0 0 0 0 1 210 0 0 0
bne_n 0 00209863 204 5 5 0 3 0000000 0 0 0 0 0 0 0 0 0 0 0 0
blt_t 0 0020c863 300 ffffffff 1 0 3 0000000 0 0 0 0 0 0 0 1 310 0 0 0
bltu_n 0 0020e863 304 ffffffff 1 0 3 0000000 0 0 0 0 0 0 0 0 0 0 0 0
jal 0 100001ef 400 0 0 0 3 0000000 0 1 3 404 0 0 0 1 500 0 0 0
jalr 0 004081e7 600 1001 0 0 3 0000000 0 1 3 604 0 0 0 1 1004 0 0 0
jal_mis 0 002001ef 700 0 0 0 3 0000000 0 0 0 0 0 0 0 0 0 1 0 0
csrrw 1 340091f3 800 aaaa 0 1234 3 0000000 0 1 3 1234 1 340 aaaa 0 0 0 0 0
csrrs 0 3400a1f3 804 f0 0 f 3 0000000 0 1 3 f 1 340 ff 0 0 0 0 0
csrrc 0 3400b1f3 808 f 0 ff 3 0000000 0 1 3 ff 1 340 f0 0 0 0 0 0
csrr 0 340021f3 80c 0 0 55 3 0000000 0 1 3 55 0 0 0 0 0 0 0 0
csrrwi 0 3402d1f3 810 0 0 77 3 0000000 0 1 3 77 1 340 5 0 0 0 0 0
csrrci0 0 340071f3 814 0 0 99 3 0000000 0 1 3 99 0 0 0 0 0 0 0 0
ecall_s 0 00000073 900 0 0 0 1 0000000 0 0 0 0 0 0 0 0 0 1 9 0
ecall_m 1 00000073 904 0 0 0 3 0000000 0 0 0 0 0 0 0 0 0 1 b 0
squash 0 00508193 908 1 0 0 3 0000000 1 0 0 0 0 0 0 0 0 0 0 0
after 0 002081b3 90c 2 3 0 3 0000000 0 1 3 5 0 0 0 0 0 0 0 0
illegal 0 ffffffff a00 0 0 0 3 0000000 0 0 0 0 0 0 0 0 0 1 2 0
mret 1 30200073 a04 0 0 0 3 0000000 0 0 0 0 0 0 0 0 0 1 0 1
mret_u 1 30200073 a08 0 0 0 0 0000000 0 0 0 0 0 0 0 0 0 1 2 0
irq_mext 2 00508193 b00 1 0 0 1 1011011 0 0 0 0 0 0 0 0 0 1 8000000b 0
irq_sext 2 00508193 b04 1 0 0 1 1011001 0 0 0 0 0 0 0 0 0 1 80000009 0
irq_stim 2 00508193 b08 1 0 0 1 0100100 0 0 0 0 0 0 0 0 0 1 80000005 0
stim_m 2 00508193 b0c 1 0 0 3 0100100 0 1 3 6 0 0 0 0 0 0 0 0
irq_mtim 2 00508193 b10 1 0 0 3 1001000 0 0 0 0 0 0 0 0 0 1 80000007 0
tail 2 002081b3 b14 1 1 0 3 0000000 0 1 3 2 0 0 0 0 0 0 0 0

//--- compile.f
hw/rvPkg.sv
hw/trapPkg.sv
hw/pipeIfs.sv
hw/aluUnit.sv
hw/mulUnit.sv
hw/instrDecode.sv
hw/exeStage.sv
hw/resultStage.sv
hw/execCore.sv
verification/execCoreTb.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP      = execCoreTb
FILELIST = compile.f
OBJDIR   = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

$(OBJDIR)/V$(TOP): $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

test: $(OBJDIR)/V$(TOP)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)
